// ==== Makefile ====
SRCS := $(shell cat verilog.f)

obj_dir/Vrename_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module rename_tb -f verilog.f

run: obj_dir/Vrename_tb
	./obj_dir/Vrename_tb +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== arch_map_table.sv ====
module arch_map_table #(
    parameter int ARCH_REGS = rename_pkg::arch_regs,
    parameter int N         = rename_pkg::width
) (
    input  logic                                 clock,
    input  logic                                 reset,

    input  logic [N-1:0]                         ret_valid,
    input  rename_pkg::reg_idx_t  [N-1:0]        ret_arch,
    input  rename_pkg::phys_idx_t [N-1:0]        ret_tag,

    output rename_pkg::map_entry_t [ARCH_REGS:0] entries   // committed mapping
);

    // retired values are final, so committed entries are always ready
    always_ff @(posedge clock) begin
        if (reset) begin
            entries[0] <= '0;
            for (int a = 1; a <= ARCH_REGS; a++) begin
                entries[a] <= rename_pkg::identity_entry(a);
            end
        end else begin
            // later slot wins when two retires hit the same arch reg
            for (int i = 0; i < N; i++) begin
                if (ret_valid[i]) begin
                    entries[ret_arch[i]].tag   <= ret_tag[i];
                    entries[ret_arch[i]].ready <= 1'b1;
                    entries[ret_arch[i]].valid <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== free_list.sv ====
module free_list #(
    parameter int ARCH_REGS = rename_pkg::arch_regs,
    parameter int PHYS_REGS = rename_pkg::phys_regs,
    parameter int N         = rename_pkg::width
) (
    input  logic                          clock,
    input  logic                          reset,

    input  logic [N-1:0]                  alloc_valid,  // slots taking a tag this cycle
    input  logic [N-1:0]                  free_valid,   // retiring slots
    input  rename_pkg::phys_idx_t [N-1:0] free_tag,     // t_old of each retiring slot
    input  logic                          recover,

    output rename_pkg::phys_idx_t [N-1:0] new_tag,
    output logic                          stall
);

    localparam int PTR_W     = $clog2(PHYS_REGS);
    localparam int INIT_FREE = PHYS_REGS - ARCH_REGS;

    rename_pkg::phys_idx_t buffer [PHYS_REGS];

    logic [PTR_W-1:0] head;       // next tag to hand out
    logic [PTR_W-1:0] tail;       // next free slot for a returned tag
    logic [PTR_W-1:0] ret_head;   // head as seen by retirement
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   n_alloc;
    logic [PTR_W:0]   n_free;
    logic [PTR_W-1:0] free_ptr [N];

    // circular pointer step, PHYS_REGS need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                                 input logic [PTR_W:0]   step);
        logic [PTR_W+1:0] sum;
        sum = ptr + step;
        if (sum >= (PTR_W+2)'(PHYS_REGS)) begin
            sum = sum - (PTR_W+2)'(PHYS_REGS);
        end
        return sum[PTR_W-1:0];
    endfunction

    always_comb begin
        if (tail >= head) begin
            count = {1'b0, tail} - {1'b0, head};
        end else begin
            count = {1'b0, tail} + (PTR_W+1)'(PHYS_REGS) - {1'b0, head};
        end
    end

    assign stall = count < (PTR_W+1)'(N);

    // allocating slots are packed onto consecutive tags from the head
    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < N; i++) begin
            new_tag[i] = buffer[ptr_add(head, (PTR_W+1)'(rename_pkg::slots_before(
                                32'(alloc_valid), i)))];
            if (alloc_valid[i]) begin
                n_alloc = n_alloc + 1'b1;
            end
        end
    end

    // returned tags go to the tail in slot order
    always_comb begin
        n_free = '0;
        for (int i = 0; i < N; i++) begin
            free_ptr[i] = ptr_add(tail, n_free);
            if (free_valid[i]) begin
                n_free = n_free + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < INIT_FREE; k++) begin
                buffer[k] <= rename_pkg::phys_idx_t'(ARCH_REGS + 1 + k);   // tags above the identity map
            end
            head     <= '0;
            ret_head <= '0;
            tail     <= PTR_W'(INIT_FREE);
        end else begin
            for (int i = 0; i < N; i++) begin
                if (free_valid[i]) begin
                    buffer[free_ptr[i]] <= free_tag[i];
                end
            end
            tail     <= ptr_add(tail, n_free);
            ret_head <= ptr_add(ret_head, n_free);
            if (recover) begin
                head <= ret_head;   // drop every speculative allocation
            end else if (!stall) begin
                head <= ptr_add(head, n_alloc);
            end
        end
    end

endmodule

// ==== map_table.sv ====
module map_table #(
    parameter int ARCH_REGS = rename_pkg::arch_regs,
    parameter int N         = rename_pkg::width
) (
    input  logic                                   clock,
    input  logic                                   reset,

    input  logic [N-1:0]                           in_valid,
    input  logic                                   do_rename,   // free list not stalling
    input  rename_pkg::reg_idx_t  [N-1:0]          src1_idx,
    input  rename_pkg::reg_idx_t  [N-1:0]          src2_idx,
    input  rename_pkg::reg_idx_t  [N-1:0]          dest_idx,
    input  rename_pkg::phys_idx_t [N-1:0]          new_tag,     // from the free list

    input  logic [N-1:0]                           cdb_valid,
    input  rename_pkg::reg_idx_t  [N-1:0]          cdb_arch,
    input  rename_pkg::phys_idx_t [N-1:0]          cdb_tag,

    input  logic                                   recover,
    input  rename_pkg::map_entry_t [ARCH_REGS:0]   arch_entries,

    output rename_pkg::phys_idx_t [N-1:0]          src1_tag,
    output logic [N-1:0]                           src1_ready,
    output rename_pkg::phys_idx_t [N-1:0]          src2_tag,
    output logic [N-1:0]                           src2_ready,
    output rename_pkg::phys_idx_t [N-1:0]          t_old
);

    // entry 0 is kept but never mapped, so arch indices need no offset
    rename_pkg::map_entry_t [ARCH_REGS:0] entries;
    rename_pkg::map_entry_t [ARCH_REGS:0] next_entries;

    always_comb begin
        next_entries = entries;

        // recovery: committed mapping, every value already written
        if (recover) begin
            for (int a = 1; a <= ARCH_REGS; a++) begin
                next_entries[a]       = arch_entries[a];
                next_entries[a].ready = 1'b1;
            end
        end

        // completions only count while the arch reg still points at that tag
        for (int i = 0; i < N; i++) begin
            if (cdb_valid[i] && (next_entries[cdb_arch[i]].tag == cdb_tag[i])) begin
                next_entries[cdb_arch[i]].ready = 1'b1;
            end
        end

        // slot by slot, so a later slot sees the mapping made by an earlier one
        for (int i = 0; i < N; i++) begin
            src1_tag[i]   = next_entries[src1_idx[i]].tag;
            src1_ready[i] = next_entries[src1_idx[i]].ready;
            src2_tag[i]   = next_entries[src2_idx[i]].tag;
            src2_ready[i] = next_entries[src2_idx[i]].ready;
            t_old[i]      = next_entries[dest_idx[i]].tag;   // read before overwrite

            if (in_valid[i] && do_rename && !recover) begin
                next_entries[dest_idx[i]].tag   = new_tag[i];
                next_entries[dest_idx[i]].ready = 1'b0;      // producer still in flight
                next_entries[dest_idx[i]].valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries[0] <= '0;
            for (int a = 1; a <= ARCH_REGS; a++) begin
                entries[a] <= rename_pkg::identity_entry(a);
            end
        end else begin
            entries <= next_entries;
        end
    end

endmodule

// ==== rename_pkg.sv ====
package rename_pkg;

    // default sizes, picked up by the top-level parameters
    localparam int arch_regs = 32;   // entries 1..32, entry 0 unused
    localparam int phys_regs = 64;   // tags 1..64, tag 0 never handed out
    localparam int width     = 2;    // rename width N

    // index types are sized for up to 63 arch regs and 127 tags
    typedef logic [5:0] reg_idx_t;
    typedef logic [6:0] phys_idx_t;

    // one map table entry
    typedef struct packed {
        phys_idx_t tag;    // physical tag currently holding the arch reg
        logic      ready;  // value written back on the CDB
        logic      valid;
    } map_entry_t;

    // reset value of entry a: identity mapping, ready
    function automatic map_entry_t identity_entry(input int a);
        map_entry_t e;
        e.tag   = phys_idx_t'(a);
        e.ready = 1'b1;
        e.valid = 1'b1;
        return e;
    endfunction

    // number of set bits below slot, used to pack slot requests onto a FIFO
    function automatic int slots_before(input logic [31:0] mask, input int slot);
        int n;
        n = 0;
        for (int i = 0; i < slot; i++) begin
            if (mask[i]) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

endpackage

// ==== rename_props.sv ====
module rename_props #(
    parameter int ARCH_REGS = rename_pkg::arch_regs,
    parameter int PHYS_REGS = rename_pkg::phys_regs,
    parameter int N         = rename_pkg::width
) (
    input logic                          clock,
    input logic                          reset,
    input logic [N-1:0]                  in_valid,
    input rename_pkg::reg_idx_t  [N-1:0] src1_idx,
    input rename_pkg::reg_idx_t  [N-1:0] src2_idx,
    input rename_pkg::reg_idx_t  [N-1:0] dest_idx,
    input rename_pkg::phys_idx_t [N-1:0] src1_tag,
    input logic [N-1:0]                  src1_ready,
    input rename_pkg::phys_idx_t [N-1:0] src2_tag,
    input logic [N-1:0]                  src2_ready,
    input rename_pkg::phys_idx_t [N-1:0] t_old,
    input rename_pkg::phys_idx_t [N-1:0] new_tag,
    input logic                          stall,
    input logic [N-1:0]                  cdb_valid,
    input rename_pkg::reg_idx_t  [N-1:0] cdb_arch,
    input rename_pkg::phys_idx_t [N-1:0] cdb_tag,
    input logic [N-1:0]                  ret_valid,
    input rename_pkg::reg_idx_t  [N-1:0] ret_arch,
    input rename_pkg::phys_idx_t [N-1:0] ret_tag,
    input rename_pkg::phys_idx_t [N-1:0] ret_t_old,
    input logic                          recover
);

    rename_pkg::phys_idx_t         spec [ARCH_REGS+1];   // shadow speculative map
    rename_pkg::phys_idx_t         com  [ARCH_REGS+1];   // shadow committed map
    logic                          rdy  [ARCH_REGS+1];
    logic [PHYS_REGS:0]            used;                 // mapped or still in flight
    rename_pkg::phys_idx_t [N-1:0] exp_tag;
    rename_pkg::phys_idx_t [N-1:0] exp_tag2;
    rename_pkg::phys_idx_t [N-1:0] exp_old;
    logic [N-1:0]                  exp_rdy;
    logic [N-1:0]                  exp_rdy2;
    logic                          tags_ok;
    logic                          renaming;
    int                            errors = 0;

    assign renaming = !stall && !recover;

    always_comb begin
        tags_ok = 1'b1;
        for (int i = 0; i < N; i++) begin
            exp_tag[i]  = spec[src1_idx[i]];
            exp_rdy[i]  = rdy[src1_idx[i]];
            exp_tag2[i] = spec[src2_idx[i]];
            exp_rdy2[i] = rdy[src2_idx[i]];
            exp_old[i]  = spec[dest_idx[i]];
            for (int j = 0; j < N; j++) begin
                if (cdb_valid[j] && cdb_arch[j] == src1_idx[i] && cdb_tag[j] == exp_tag[i]) begin
                    exp_rdy[i] = 1'b1;   // completion bypassed to this lookup
                end
                if (cdb_valid[j] && cdb_arch[j] == src2_idx[i]
                        && cdb_tag[j] == exp_tag2[i]) begin
                    exp_rdy2[i] = 1'b1;
                end
            end
            // earlier slots of the group win
            for (int j = 0; j < i; j++) begin
                if (in_valid[j] && renaming && dest_idx[j] == src1_idx[i]) begin
                    exp_tag[i] = new_tag[j];
                    exp_rdy[i] = 1'b0;
                end
                if (in_valid[j] && renaming && dest_idx[j] == src2_idx[i]) begin
                    exp_tag2[i] = new_tag[j];
                    exp_rdy2[i] = 1'b0;
                end
                if (in_valid[j] && renaming && dest_idx[j] == dest_idx[i]) begin
                    exp_old[i] = new_tag[j];
                end
                if (in_valid[j] && in_valid[i] && new_tag[j] == new_tag[i]) begin
                    tags_ok = 1'b0;
                end
            end
            if (in_valid[i] && (new_tag[i] == '0 || used[new_tag[i]])) begin
                tags_ok = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a <= ARCH_REGS; a++) begin
                spec[a] <= rename_pkg::phys_idx_t'(a);
                com[a]  <= rename_pkg::phys_idx_t'(a);
                rdy[a]  <= 1'b1;
            end
            used <= {{(PHYS_REGS-ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}, 1'b0};
        end else begin
            for (int j = 0; j < N; j++) begin
                if (cdb_valid[j] && spec[cdb_arch[j]] == cdb_tag[j]) begin
                    rdy[cdb_arch[j]] <= 1'b1;
                end
            end
            for (int i = 0; i < N; i++) begin
                if (in_valid[i] && renaming) begin
                    spec[dest_idx[i]] <= new_tag[i];
                    rdy[dest_idx[i]]  <= 1'b0;
                    used[new_tag[i]]  <= 1'b1;
                end
                if (ret_valid[i]) begin
                    com[ret_arch[i]]   <= ret_tag[i];
                    used[ret_t_old[i]] <= 1'b0;   // old mapping is dead
                end
            end
            if (recover) begin
                spec <= com;
                used <= '0;
                for (int a = 1; a <= ARCH_REGS; a++) begin
                    rdy[a]       <= 1'b1;
                    used[com[a]] <= 1'b1;   // only committed tags survive
                end
            end
        end
    end

    a_src_tag: assert property (@(posedge clock) disable iff (reset)
        !recover |-> src1_tag == exp_tag)
        else begin
            $error("Fail src1_tag: got %h expected %h", $sampled(src1_tag), $sampled(exp_tag));
            errors++;
        end

    a_src_ready: assert property (@(posedge clock) disable iff (reset)
        !recover |-> src1_ready == exp_rdy)
        else begin
            $error("Fail src1_ready: got %h expected %h", $sampled(src1_ready),
                   $sampled(exp_rdy));
            errors++;
        end

    a_src2_tag: assert property (@(posedge clock) disable iff (reset)
        !recover |-> src2_tag == exp_tag2)
        else begin
            $error("Fail src2_tag: got %h expected %h", $sampled(src2_tag),
                   $sampled(exp_tag2));
            errors++;
        end

    a_src2_ready: assert property (@(posedge clock) disable iff (reset)
        !recover |-> src2_ready == exp_rdy2)
        else begin
            $error("Fail src2_ready: got %h expected %h", $sampled(src2_ready),
                   $sampled(exp_rdy2));
            errors++;
        end

    a_t_old: assert property (@(posedge clock) disable iff (reset)
        !recover |-> t_old == exp_old)
        else begin
            $error("Fail t_old: got %h expected %h", $sampled(t_old), $sampled(exp_old));
            errors++;
        end

    a_new_tag: assert property (@(posedge clock) disable iff (reset)
        (in_valid != '0 && renaming) |-> tags_ok)
        else begin
            $error("new_tag %h is zero, repeated in its group or already in use",
                   $sampled(new_tag));
            errors++;
        end

    a_stall: assert property (@(posedge clock) disable iff (reset)
        stall == ((PHYS_REGS - $countones(used)) < N))
        else begin
            $error("Fail stall: got %h expected %h", $sampled(stall),
                   (PHYS_REGS - $countones($sampled(used))) < N);
            errors++;
        end

endmodule

// ==== rename_tb.sv ====
module rename_tb;

    localparam int N    = rename_pkg::width;
    localparam int ARCH = rename_pkg::arch_regs;
    // cycles per test: reset, lookups, deps, alloc, cdb, stall, random plus recover
    localparam int budget = 4 + 17 + 6 + 7 + 6 + 52 + 47 + 100;

    logic                          clock = 1'b0;
    logic                          reset;
    logic [N-1:0]                  in_valid;
    rename_pkg::reg_idx_t  [N-1:0] src1_idx;
    rename_pkg::reg_idx_t  [N-1:0] src2_idx;
    rename_pkg::reg_idx_t  [N-1:0] dest_idx;
    rename_pkg::phys_idx_t [N-1:0] src1_tag;
    logic [N-1:0]                  src1_ready;
    rename_pkg::phys_idx_t [N-1:0] src2_tag;
    logic [N-1:0]                  src2_ready;
    rename_pkg::phys_idx_t [N-1:0] t_old;
    rename_pkg::phys_idx_t [N-1:0] new_tag;
    logic                          stall;
    logic [N-1:0]                  cdb_valid;
    rename_pkg::reg_idx_t  [N-1:0] cdb_arch;
    rename_pkg::phys_idx_t [N-1:0] cdb_tag;
    logic [N-1:0]                  ret_valid;
    rename_pkg::reg_idx_t  [N-1:0] ret_arch;
    rename_pkg::phys_idx_t [N-1:0] ret_tag;
    rename_pkg::phys_idx_t [N-1:0] ret_t_old;
    logic                          recover;

    // renamed but not yet retired, oldest first
    rename_pkg::reg_idx_t  q_arch [$];
    rename_pkg::phys_idx_t q_tag  [$];
    rename_pkg::phys_idx_t q_old  [$];
    int tb_errors   = 0;
    int last_errors = 0;
    int tests       = 0;

    rename_unit DUT (.*);

    bind rename_unit rename_props #(
        .ARCH_REGS (ARCH_REGS),
        .PHYS_REGS (PHYS_REGS),
        .N         (N)
    ) u_props (.*);

    always #5 clock = ~clock;

    function automatic rename_pkg::reg_idx_t random_arch();
        return rename_pkg::reg_idx_t'($urandom_range(ARCH, 1));
    endfunction

    task automatic idle_inputs();
        @(negedge clock);
        in_valid  = '0;
        cdb_valid = '0;
        ret_valid = '0;
        recover   = 1'b0;
    endtask

    task automatic lookup(input rename_pkg::reg_idx_t a0, input rename_pkg::reg_idx_t a1);
        idle_inputs();
        src1_idx[0] = a0;
        src1_idx[1] = a1;
    endtask

    task automatic rename_pair(input rename_pkg::reg_idx_t d0, input rename_pkg::reg_idx_t d1,
                               input rename_pkg::reg_idx_t s0);
        idle_inputs();
        in_valid    = '1;
        dest_idx[0] = d0;
        dest_idx[1] = d1;
        src1_idx[0] = s0;
        src1_idx[1] = d0;   // slot 1 reads slot 0's dest
        src2_idx[0] = d1;
        src2_idx[1] = s0;
        #1;
        if (!stall) begin
            for (int i = 0; i < N; i++) begin
                q_arch.push_back(dest_idx[i]);
                q_tag.push_back(new_tag[i]);
                q_old.push_back(t_old[i]);
            end
        end
    endtask

    task automatic retire_pair();
        idle_inputs();
        for (int i = 0; i < N; i++) begin
            if (q_arch.size() > 0) begin
                ret_valid[i] = 1'b1;
                ret_arch[i]  = q_arch.pop_front();
                ret_tag[i]   = q_tag.pop_front();
                ret_t_old[i] = q_old.pop_front();
            end
        end
    endtask

    task automatic complete(input rename_pkg::reg_idx_t arch, input rename_pkg::phys_idx_t tag);
        idle_inputs();
        cdb_valid[0] = 1'b1;
        cdb_arch[0]  = arch;
        cdb_tag[0]   = tag;
        src1_idx[0]  = arch;   // same-cycle bypass
    endtask

    task automatic recover_pulse();
        idle_inputs();
        recover = 1'b1;
        q_arch.delete();   // speculative work is squashed
        q_tag.delete();
        q_old.delete();
    endtask

    task automatic finish_test(input string name);
        int now_errors;
        idle_inputs();
        now_errors = DUT.u_props.errors + tb_errors;
        $display("%s: %0d failures", name, now_errors - last_errors);
        last_errors = now_errors;
        tests++;
    endtask

    initial begin
        int total;
        void'($urandom(32'hbee68428));
        reset     = 1'b1;
        in_valid  = '0;
        src1_idx  = {N{6'd1}};
        src2_idx  = {N{6'd1}};
        dest_idx  = {N{6'd1}};
        cdb_valid = '0;
        cdb_arch  = {N{6'd1}};
        cdb_tag   = '0;
        ret_valid = '0;
        ret_arch  = {N{6'd1}};
        ret_tag   = '0;
        ret_t_old = '0;
        recover   = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int a = 1; a <= ARCH; a += 2) begin
            lookup(a, a + 1);
        end
        finish_test("reset_lookup");

        for (int k = 0; k < 3; k++) begin
            rename_pair(5, 6, 5);
        end
        rename_pair(9, 9, 6);   // same dest twice in one group
        lookup(5, 9);
        finish_test("rename_dependency");

        for (int k = 0; k < 6; k++) begin
            rename_pair(random_arch(), random_arch(), random_arch());
        end
        finish_test("tag_allocation");

        rename_pair(7, 8, 1);
        rename_pair(7, 8, 1);
        complete(7, q_tag[q_tag.size() - 4]);   // stale tag
        complete(7, q_tag[q_tag.size() - 2]);
        lookup(7, 8);
        finish_test("cdb_ready");

        for (int k = 0; k < 40 && !stall; k++) begin
            rename_pair(random_arch(), random_arch(), random_arch());
        end
        rename_pair(3, 4, 3);   // held while stalled
        if (!stall) begin
            $display("stall did not rise after the free list ran out");
            tb_errors++;
        end
        for (int k = 0; k < 8 && stall; k++) begin
            retire_pair();
        end
        if (stall) begin
            $display("stall stayed high after tags were retired");
            tb_errors++;
        end
        finish_test("stall_fill");

        for (int k = 0; k < 12; k++) begin
            retire_pair();
            rename_pair(random_arch(), random_arch(), random_arch());
        end
        recover_pulse();
        for (int a = 1; a <= ARCH; a += 2) begin
            lookup(a, a + 1);
        end
        for (int k = 0; k < 4; k++) begin
            rename_pair(random_arch(), random_arch(), random_arch());
        end
        finish_test("random_recover");

        total = DUT.u_props.errors + tb_errors;
        $display("%0d tests, %0d failures", tests, total);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(budget * 10);
        $display("timeout, the tests did not finish within %0d cycles", budget);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== rename_unit.sv ====
module rename_unit #(
    parameter int ARCH_REGS = rename_pkg::arch_regs,
    parameter int PHYS_REGS = rename_pkg::phys_regs,
    parameter int N         = rename_pkg::width
) (
    input  logic                          clock,
    input  logic                          reset,

    // rename, from and to the decode side
    input  logic [N-1:0]                  in_valid,
    input  rename_pkg::reg_idx_t  [N-1:0] src1_idx,
    input  rename_pkg::reg_idx_t  [N-1:0] src2_idx,
    input  rename_pkg::reg_idx_t  [N-1:0] dest_idx,
    output rename_pkg::phys_idx_t [N-1:0] src1_tag,
    output logic [N-1:0]                  src1_ready,
    output rename_pkg::phys_idx_t [N-1:0] src2_tag,
    output logic [N-1:0]                  src2_ready,
    output rename_pkg::phys_idx_t [N-1:0] t_old,
    output rename_pkg::phys_idx_t [N-1:0] new_tag,
    output logic                          stall,

    // completion
    input  logic [N-1:0]                  cdb_valid,
    input  rename_pkg::reg_idx_t  [N-1:0] cdb_arch,
    input  rename_pkg::phys_idx_t [N-1:0] cdb_tag,

    // retirement
    input  logic [N-1:0]                  ret_valid,
    input  rename_pkg::reg_idx_t  [N-1:0] ret_arch,
    input  rename_pkg::phys_idx_t [N-1:0] ret_tag,
    input  rename_pkg::phys_idx_t [N-1:0] ret_t_old,

    input  logic                          recover
);

    logic                                 do_rename;
    logic [N-1:0]                         alloc_valid;
    rename_pkg::map_entry_t [ARCH_REGS:0] arch_entries;

    assign do_rename   = !stall;
    assign alloc_valid = in_valid & {N{do_rename}};   // whole group waits on a stall

    map_table #(
        .ARCH_REGS (ARCH_REGS),
        .N         (N)
    ) u_map_table (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (in_valid),
        .do_rename    (do_rename),
        .src1_idx     (src1_idx),
        .src2_idx     (src2_idx),
        .dest_idx     (dest_idx),
        .new_tag      (new_tag),
        .cdb_valid    (cdb_valid),
        .cdb_arch     (cdb_arch),
        .cdb_tag      (cdb_tag),
        .recover      (recover),
        .arch_entries (arch_entries),
        .src1_tag     (src1_tag),
        .src1_ready   (src1_ready),
        .src2_tag     (src2_tag),
        .src2_ready   (src2_ready),
        .t_old        (t_old)
    );

    free_list #(
        .ARCH_REGS (ARCH_REGS),
        .PHYS_REGS (PHYS_REGS),
        .N         (N)
    ) u_free_list (
        .clock       (clock),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .free_valid  (ret_valid),
        .free_tag    (ret_t_old),   // old mapping of a retired dest is dead
        .recover     (recover),
        .new_tag     (new_tag),
        .stall       (stall)
    );

    arch_map_table #(
        .ARCH_REGS (ARCH_REGS),
        .N         (N)
    ) u_arch_map_table (
        .clock     (clock),
        .reset     (reset),
        .ret_valid (ret_valid),
        .ret_arch  (ret_arch),
        .ret_tag   (ret_tag),
        .entries   (arch_entries)
    );

endmodule

// ==== verilog.f ====
rename_pkg.sv
map_table.sv
free_list.sv
arch_map_table.sv
rename_unit.sv
rename_props.sv
rename_tb.sv
